// File: floo_pkg.sv
// Shared NoC types; coordinates are 3 bits per axis and every flit must start with dst_id
package floo_pkg;

  // ======================================================================
  // Router ports and coordinates
  // ======================================================================

  localparam int NumDirections = 5;

  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Eject = 3'd4   // Local endpoint
  } route_dir_e;

  localparam int XWidth = 3;
  localparam int YWidth = 3;

  typedef struct packed {
    logic [XWidth-1:0] x;
    logic [YWidth-1:0] y;
  } xy_id_t;

  // ======================================================================
  // Flit types, one per network
  // ======================================================================

  // Narrow request network, 44 bits
  typedef struct packed {
    xy_id_t      dst_id;
    xy_id_t      src_id;
    logic [31:0] payload;
  } floo_req_flit_t;

  // Narrow response network, 22 bits
  typedef struct packed {
    xy_id_t      dst_id;
    logic [15:0] payload;
  } floo_rsp_flit_t;

  // Wide data network, 76 bits
  typedef struct packed {
    xy_id_t      dst_id;
    xy_id_t      src_id;
    logic [63:0] payload;
  } floo_wide_flit_t;

endpackage

// File: floo_fifo.sv
// Channel FIFO; Depth must be at least 1 and ready_o depends combinationally on ready_i when full
`timescale 1ns/1ps

module floo_fifo #(
  parameter int unsigned Depth  = 2,
  parameter type         flit_t = floo_pkg::floo_req_flit_t
) (
  input  logic  clk_i,
  input  logic  reset_i,
  input  logic  valid_i,
  output logic  ready_o,
  input  flit_t data_i,
  output logic  valid_o,
  input  logic  ready_i,
  output flit_t data_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [PtrWidth-1:0] LastIdx = PtrWidth'(Depth - 1);
  localparam logic [PtrWidth:0]   Full    = (PtrWidth + 1)'(Depth);

  flit_t               mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [PtrWidth:0]   count_q;
  logic                full, empty, push, pop;

  assign full    = (count_q == Full);
  assign empty   = (count_q == '0);
  assign ready_o = ~full | ready_i;   // A pop frees a slot this cycle
  assign push    = valid_i & ready_o;
  assign pop     = ready_i & ~empty;
  assign valid_o = ~empty;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastIdx) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastIdx) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Never more flits held than slots
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    count_q <= Full);

endmodule

// File: floo_route_select.sv
// XY route computation; flit_t must carry a dst_id field of type xy_id_t
`timescale 1ns/1ps

module floo_route_select #(
  parameter type flit_t = floo_pkg::floo_req_flit_t
) (
  input  floo_pkg::xy_id_t                  xy_id_i,
  input  logic                              valid_i,
  input  flit_t                             flit_i,
  output logic [floo_pkg::NumDirections-1:0] route_o
);

  floo_pkg::xy_id_t     dst;
  floo_pkg::route_dir_e dir;

  assign dst = flit_i.dst_id;

  // X first, then Y
  always_comb begin
    if (dst.x > xy_id_i.x) begin
      dir = floo_pkg::East;
    end else if (dst.x < xy_id_i.x) begin
      dir = floo_pkg::West;
    end else if (dst.y > xy_id_i.y) begin
      dir = floo_pkg::North;
    end else if (dst.y < xy_id_i.y) begin
      dir = floo_pkg::South;
    end else begin
      dir = floo_pkg::Eject;
    end
  end

  always_comb begin
    route_o = '0;
    if (valid_i) begin
      route_o[dir] = 1'b1;
    end
  end

endmodule

// File: floo_switch_alloc.sv
// Round-robin switch allocator; NumPorts >= 2 and each input requests at most one output
`timescale 1ns/1ps

module floo_switch_alloc #(
  parameter int unsigned NumPorts = floo_pkg::NumDirections
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic [NumPorts-1:0][NumPorts-1:0]  route_req_i,  // [input][output]
  input  logic [NumPorts-1:0]                out_ready_i,
  output logic [NumPorts-1:0][NumPorts-1:0]  grant_o,      // [output][input]
  output logic [NumPorts-1:0]                pop_o
);

  localparam int unsigned IdxWidth = $clog2(NumPorts);
  localparam logic [IdxWidth-1:0] LastIdx = IdxWidth'(NumPorts - 1);

  logic [NumPorts-1:0][IdxWidth-1:0] ptr_q;
  logic [NumPorts-1:0][IdxWidth-1:0] win_idx;

  // ======================================================================
  // One arbiter per output, search starts at the pointer
  // ======================================================================

  always_comb begin
    int unsigned idx;
    logic        found;
    grant_o = '0;
    win_idx = '0;
    for (int unsigned o = 0; o < NumPorts; o++) begin
      found = 1'b0;
      for (int unsigned k = 0; k < NumPorts; k++) begin
        idx = (int'(ptr_q[o]) + k) % NumPorts;
        if (!found && route_req_i[idx][o]) begin
          found           = 1'b1;
          grant_o[o][idx] = 1'b1;
          win_idx[o]      = IdxWidth'(idx);
        end
      end
    end
  end

  // Pointer moves past the winner only on a completed transfer
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else begin
      for (int unsigned o = 0; o < NumPorts; o++) begin
        if (|grant_o[o] && out_ready_i[o]) begin
          ptr_q[o] <= (win_idx[o] == LastIdx) ? '0 : win_idx[o] + 1'b1;
        end else if (|grant_o[o]) begin
          ptr_q[o] <= win_idx[o];   // Stall locks the winner
        end
      end
    end
  end

  // ======================================================================
  // Pops per input
  // ======================================================================

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    logic [NumPorts-1:0] granted_outs;

    for (genvar o = 0; o < NumPorts; o++) begin : gen_col
      assign granted_outs[o] = grant_o[o][i];
    end

    assign pop_o[i] = |(granted_outs & out_ready_i);

    // Relies on route select asking for one port per head flit
    a_single_grant: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(granted_outs));
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    // Stalled winner keeps its grant, its FIFO head does not move
    a_grant_held: assert property (@(posedge clk_i) disable iff (reset_i)
      (|grant_o[o] && !out_ready_i[o]) |=> (grant_o[o] == $past(grant_o[o])));
  end

endmodule

// File: floo_router.sv
// Single-channel XY router; NumPorts must equal NumDirections and each flit is a whole packet
`timescale 1ns/1ps

module floo_router #(
  parameter int unsigned NumPorts         = floo_pkg::NumDirections,
  parameter int unsigned ChannelFifoDepth = 2,
  parameter type         flit_t           = floo_pkg::floo_req_flit_t
) (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  floo_pkg::xy_id_t            xy_id_i,
  input  logic         [NumPorts-1:0] valid_i,
  output logic         [NumPorts-1:0] ready_o,
  input  flit_t        [NumPorts-1:0] data_i,
  output logic         [NumPorts-1:0] valid_o,
  input  logic         [NumPorts-1:0] ready_i,
  output flit_t        [NumPorts-1:0] data_o
);

  logic  [NumPorts-1:0]               head_valid;
  flit_t [NumPorts-1:0]               head_flit;
  logic  [NumPorts-1:0][NumPorts-1:0] route_req;  // [input][output]
  logic  [NumPorts-1:0][NumPorts-1:0] grant;      // [output][input]
  logic  [NumPorts-1:0]               pop;

  // ======================================================================
  // Input stage
  // ======================================================================

  for (genvar i = 0; i < NumPorts; i++) begin : gen_in
    floo_fifo #(
      .Depth  ( ChannelFifoDepth ),
      .flit_t ( flit_t           )
    ) u_fifo (
      .clk_i   ( clk_i         ),
      .reset_i ( reset_i       ),
      .valid_i ( valid_i[i]    ),
      .ready_o ( ready_o[i]    ),
      .data_i  ( data_i[i]     ),
      .valid_o ( head_valid[i] ),
      .ready_i ( pop[i]        ),
      .data_o  ( head_flit[i]  )
    );

    floo_route_select #(
      .flit_t ( flit_t )
    ) u_route_select (
      .xy_id_i ( xy_id_i       ),
      .valid_i ( head_valid[i] ),
      .flit_i  ( head_flit[i]  ),
      .route_o ( route_req[i]  )
    );
  end

  floo_switch_alloc #(
    .NumPorts ( NumPorts )
  ) u_switch_alloc (
    .clk_i       ( clk_i     ),
    .reset_i     ( reset_i   ),
    .route_req_i ( route_req ),
    .out_ready_i ( ready_i   ),
    .grant_o     ( grant     ),
    .pop_o       ( pop       )
  );

  // ======================================================================
  // Crossbar
  // ======================================================================

  always_comb begin
    data_o = '0;
    for (int unsigned o = 0; o < NumPorts; o++) begin
      for (int unsigned i = 0; i < NumPorts; i++) begin
        if (grant[o][i]) begin
          data_o[o] = head_flit[i];
        end
      end
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_out
    assign valid_o[o] = |grant[o];

    // Back-pressure holds the offer across FIFO and allocator
    a_out_stable: assert property (@(posedge clk_i) disable iff (reset_i)
      (valid_o[o] && !ready_i[o]) |=> valid_o[o] && (data_o[o] == $past(data_o[o])));
  end

endmodule

// File: floo_narrow_wide_router.sv
// Request, response and wide routers at one mesh node; the three networks share only xy_id_i
`timescale 1ns/1ps

module floo_narrow_wide_router #(
  parameter int unsigned ChannelFifoDepth = 2
) (
  input  logic                                                          clk_i,
  input  logic                                                          reset_i,
  input  floo_pkg::xy_id_t                                              xy_id_i,
  // Request network
  input  logic                      [floo_pkg::NumDirections-1:0]      req_valid_i,
  output logic                      [floo_pkg::NumDirections-1:0]      req_ready_o,
  input  floo_pkg::floo_req_flit_t  [floo_pkg::NumDirections-1:0]      req_data_i,
  output logic                      [floo_pkg::NumDirections-1:0]      req_valid_o,
  input  logic                      [floo_pkg::NumDirections-1:0]      req_ready_i,
  output floo_pkg::floo_req_flit_t  [floo_pkg::NumDirections-1:0]      req_data_o,
  // Response network
  input  logic                      [floo_pkg::NumDirections-1:0]      rsp_valid_i,
  output logic                      [floo_pkg::NumDirections-1:0]      rsp_ready_o,
  input  floo_pkg::floo_rsp_flit_t  [floo_pkg::NumDirections-1:0]      rsp_data_i,
  output logic                      [floo_pkg::NumDirections-1:0]      rsp_valid_o,
  input  logic                      [floo_pkg::NumDirections-1:0]      rsp_ready_i,
  output floo_pkg::floo_rsp_flit_t  [floo_pkg::NumDirections-1:0]      rsp_data_o,
  // Wide network
  input  logic                      [floo_pkg::NumDirections-1:0]      wide_valid_i,
  output logic                      [floo_pkg::NumDirections-1:0]      wide_ready_o,
  input  floo_pkg::floo_wide_flit_t [floo_pkg::NumDirections-1:0]      wide_data_i,
  output logic                      [floo_pkg::NumDirections-1:0]      wide_valid_o,
  input  logic                      [floo_pkg::NumDirections-1:0]      wide_ready_i,
  output floo_pkg::floo_wide_flit_t [floo_pkg::NumDirections-1:0]      wide_data_o
);

  floo_router #(
    .NumPorts         ( floo_pkg::NumDirections   ),
    .ChannelFifoDepth ( ChannelFifoDepth          ),
    .flit_t           ( floo_pkg::floo_req_flit_t )
  ) u_req_router (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .xy_id_i ( xy_id_i     ),
    .valid_i ( req_valid_i ),
    .ready_o ( req_ready_o ),
    .data_i  ( req_data_i  ),
    .valid_o ( req_valid_o ),
    .ready_i ( req_ready_i ),
    .data_o  ( req_data_o  )
  );

  floo_router #(
    .NumPorts         ( floo_pkg::NumDirections   ),
    .ChannelFifoDepth ( ChannelFifoDepth          ),
    .flit_t           ( floo_pkg::floo_rsp_flit_t )
  ) u_rsp_router (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .xy_id_i ( xy_id_i     ),
    .valid_i ( rsp_valid_i ),
    .ready_o ( rsp_ready_o ),
    .data_i  ( rsp_data_i  ),
    .valid_o ( rsp_valid_o ),
    .ready_i ( rsp_ready_i ),
    .data_o  ( rsp_data_o  )
  );

  floo_router #(
    .NumPorts         ( floo_pkg::NumDirections    ),
    .ChannelFifoDepth ( ChannelFifoDepth           ),
    .flit_t           ( floo_pkg::floo_wide_flit_t )
  ) u_wide_router (
    .clk_i   ( clk_i        ),
    .reset_i ( reset_i      ),
    .xy_id_i ( xy_id_i      ),
    .valid_i ( wide_valid_i ),
    .ready_o ( wide_ready_o ),
    .data_i  ( wide_data_i  ),
    .valid_o ( wide_valid_o ),
    .ready_i ( wide_ready_i ),
    .data_o  ( wide_data_o  )
  );

endmodule

// File: tb_floo_checker.sv
// Scoreboard for one network; output flits match queue heads, so identical flits in flight look alike
`timescale 1ns/1ps

module tb_floo_checker #(
  parameter int unsigned NumPorts = floo_pkg::NumDirections,
  parameter type         flit_t   = floo_pkg::floo_req_flit_t,
  parameter string       Name     = "req"
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  floo_pkg::xy_id_t     xy_id_i,
  input  logic  [NumPorts-1:0] in_valid_i,
  input  logic  [NumPorts-1:0] in_ready_i,
  input  flit_t [NumPorts-1:0] in_data_i,
  input  logic  [NumPorts-1:0] out_valid_i,
  input  logic  [NumPorts-1:0] out_ready_i,
  input  flit_t [NumPorts-1:0] out_data_i,
  output int unsigned          err_count_o,
  output int unsigned          xfer_count_o,
  output int unsigned          pending_o
);

  flit_t                exp_q [NumPorts][NumPorts][$];  // [input][output]
  int unsigned          wait_cnt [NumPorts][NumPorts];  // Foreign transfers while waiting
  logic  [NumPorts-1:0] stall_q = '0;
  flit_t [NumPorts-1:0] data_q;
  logic                 rst_q = 1'b0;
  int unsigned          errs = 0;
  int unsigned          xfers = 0;
  int unsigned          pending = 0;

  assign err_count_o  = errs;
  assign xfer_count_o = xfers;
  assign pending_o    = pending;

  // XY reference: North 0, East 1, South 2, West 3, Eject 4
  function automatic int unsigned xy_port(floo_pkg::xy_id_t dst, floo_pkg::xy_id_t own);
    if (dst.x > own.x) return 1;
    if (dst.x < own.x) return 3;
    if (dst.y > own.y) return 0;
    if (dst.y < own.y) return 2;
    return 4;
  endfunction

  always @(posedge clk_i) begin : watch
    logic        found;
    int unsigned others;
    if (rst_q && (out_valid_i != '0 || in_ready_i != '1)) begin
      errs++;
      $display("MISMATCH @%0t: %s valid_o=%b ready_o=%b after reset",
               $time, Name, out_valid_i, in_ready_i);
    end
    if (reset_i) begin
      for (int unsigned i = 0; i < NumPorts; i++)
        for (int unsigned o = 0; o < NumPorts; o++) wait_cnt[i][o] = 0;
    end else begin
      for (int unsigned o = 0; o < NumPorts; o++) begin
        if (stall_q[o] && (!out_valid_i[o] || out_data_i[o] != data_q[o])) begin
          errs++;
          $display("MISMATCH @%0t: %s output %0d changed while stalled", $time, Name, o);
        end
        if (out_valid_i[o] && out_ready_i[o]) begin
          xfers++;
          found = 1'b0;
          for (int unsigned i = 0; i < NumPorts; i++) begin
            if (!found && exp_q[i][o].size() != 0 && exp_q[i][o][0] == out_data_i[o]) begin
              found = 1'b1;
              void'(exp_q[i][o].pop_front());
              wait_cnt[i][o] = 0;
            end else begin
              others = 0;
              for (int unsigned x = 0; x < NumPorts; x++)
                if (x != o) others += exp_q[i][x].size();
              // Head of input i asks for o only if all its pending flits do
              if (others == 0 && exp_q[i][o].size() != 0) wait_cnt[i][o]++;
              else wait_cnt[i][o] = 0;
              if (wait_cnt[i][o] > NumPorts - 1) begin
                errs++;
                wait_cnt[i][o] = 0;
                $display("ERROR: %s input %0d was passed over more than %0d times on output %0d",
                         Name, i, NumPorts - 1, o);
              end
            end
          end
          if (!found) begin
            errs++;
            $display("MISMATCH @%0t: %s output %0d sent unexpected flit %h",
                     $time, Name, o, out_data_i[o]);
          end
        end
      end
      for (int unsigned i = 0; i < NumPorts; i++)
        if (in_valid_i[i] && in_ready_i[i])
          exp_q[i][xy_port(in_data_i[i].dst_id, xy_id_i)].push_back(in_data_i[i]);
    end
    stall_q = reset_i ? '0 : out_valid_i & ~out_ready_i;
    data_q  = out_data_i;
    rst_q   = reset_i;
    pending = 0;
    for (int unsigned i = 0; i < NumPorts; i++)
      for (int unsigned o = 0; o < NumPorts; o++) pending += exp_q[i][o].size();
  end

endmodule

// File: tb_floo_router.sv
// Testbench for the three-network router at node (2,2); LFSR stimulus, fixed seed, seven tests
`timescale 1ns/1ps

module tb_floo_router;

  localparam int unsigned NumPorts    = floo_pkg::NumDirections;
  localparam int unsigned ResetCycles = 16;
  localparam int unsigned RouteCycles = 20;   // Per probe destination
  localparam int unsigned DrainCycles = 300;
  localparam int unsigned TestCycles  = ResetCycles + 2 + NumPorts * RouteCycles
                                        + 400 + 300 + 200 + 300 + DrainCycles;

  logic                                     clk_i;
  logic                                     reset_i;
  floo_pkg::xy_id_t                         xy_id_i;
  logic [NumPorts-1:0] req_valid_i, req_ready_o, req_valid_o, req_ready_i, req_acc;
  logic [NumPorts-1:0] rsp_valid_i, rsp_ready_o, rsp_valid_o, rsp_ready_i, rsp_acc;
  logic [NumPorts-1:0] wide_valid_i, wide_ready_o, wide_valid_o, wide_ready_i, wide_acc;
  floo_pkg::floo_req_flit_t  [NumPorts-1:0] req_data_i, req_data_o;
  floo_pkg::floo_rsp_flit_t  [NumPorts-1:0] rsp_data_i, rsp_data_o;
  floo_pkg::floo_wide_flit_t [NumPorts-1:0] wide_data_i, wide_data_o;
  int unsigned req_errs, req_xfers, req_pending;
  int unsigned rsp_errs, rsp_xfers, rsp_pending;
  int unsigned wide_errs, wide_xfers, wide_pending;

  logic [31:0]      lfsr_q;
  int unsigned      offer_lvl, ready_lvl;   // Chance in eighths
  logic             req_stall, fixed_dst_en;
  floo_pkg::xy_id_t fixed_dst;
  int unsigned      tb_errs, tests_failed;

  floo_narrow_wide_router #(.ChannelFifoDepth(2)) u_dut (.*);

  tb_floo_checker #(.flit_t(floo_pkg::floo_req_flit_t), .Name("req")) u_req_check (
    .clk_i, .reset_i, .xy_id_i,
    .in_valid_i(req_valid_i), .in_ready_i(req_ready_o), .in_data_i(req_data_i),
    .out_valid_i(req_valid_o), .out_ready_i(req_ready_i), .out_data_i(req_data_o),
    .err_count_o(req_errs), .xfer_count_o(req_xfers), .pending_o(req_pending));
  tb_floo_checker #(.flit_t(floo_pkg::floo_rsp_flit_t), .Name("rsp")) u_rsp_check (
    .clk_i, .reset_i, .xy_id_i,
    .in_valid_i(rsp_valid_i), .in_ready_i(rsp_ready_o), .in_data_i(rsp_data_i),
    .out_valid_i(rsp_valid_o), .out_ready_i(rsp_ready_i), .out_data_i(rsp_data_o),
    .err_count_o(rsp_errs), .xfer_count_o(rsp_xfers), .pending_o(rsp_pending));
  tb_floo_checker #(.flit_t(floo_pkg::floo_wide_flit_t), .Name("wide")) u_wide_check (
    .clk_i, .reset_i, .xy_id_i,
    .in_valid_i(wide_valid_i), .in_ready_i(wide_ready_o), .in_data_i(wide_data_i),
    .out_valid_i(wide_valid_o), .out_ready_i(wide_ready_i), .out_data_i(wide_data_o),
    .err_count_o(wide_errs), .xfer_count_o(wide_xfers), .pending_o(wide_pending));

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  initial begin
    #(TestCycles * 4 * 10);
    $display("ERROR: watchdog expired after %0d cycles", TestCycles * 4);
    $display("** FAIL **");
    $finish;
  end

  always @(posedge clk_i) begin
    req_acc  <= req_valid_i & req_ready_o;
    rsp_acc  <= rsp_valid_i & rsp_ready_o;
    wide_acc <= wide_valid_i & wide_ready_o;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int unsigned n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int unsigned k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic logic chance(input int unsigned lvl);
    int unsigned r;
    r = 32'(rand_bits(3));
    return r < lvl;
  endfunction

  function automatic floo_pkg::xy_id_t pick_dst();
    floo_pkg::xy_id_t d;
    d = 6'(rand_bits(6));
    return fixed_dst_en ? fixed_dst : d;
  endfunction

  function automatic floo_pkg::xy_id_t probe_dst(input int unsigned dir);
    case (dir)
      0:       return '{x: 3'd2, y: 3'd3};  // North
      1:       return '{x: 3'd3, y: 3'd2};
      2:       return '{x: 3'd2, y: 3'd1};
      3:       return '{x: 3'd1, y: 3'd2};
      default: return '{x: 3'd2, y: 3'd2};  // Eject
    endcase
  endfunction

  function automatic int unsigned total_errs();
    return req_errs + rsp_errs + wide_errs + tb_errs;
  endfunction

  function automatic logic busy();
    return (req_pending + rsp_pending + wide_pending) != 0
           || |req_valid_i || |rsp_valid_i || |wide_valid_i;
  endfunction

  // An offer stays until its acceptance was seen at the last rising edge
  task automatic drive_inputs();
    for (int p = 0; p < NumPorts; p++) begin
      if (!req_valid_i[p] || req_acc[p]) begin
        req_valid_i[p]         = chance(offer_lvl);
        req_data_i[p].dst_id   = pick_dst();
        req_data_i[p].src_id   = 6'(rand_bits(6));
        req_data_i[p].payload  = 32'(rand_bits(32));
      end
      if (!rsp_valid_i[p] || rsp_acc[p]) begin
        rsp_valid_i[p]         = chance(offer_lvl);
        rsp_data_i[p].dst_id   = pick_dst();
        rsp_data_i[p].payload  = 16'(rand_bits(16));
      end
      if (!wide_valid_i[p] || wide_acc[p]) begin
        wide_valid_i[p]        = chance(offer_lvl);
        wide_data_i[p].dst_id  = pick_dst();
        wide_data_i[p].src_id  = 6'(rand_bits(6));
        wide_data_i[p].payload = rand_bits(64);
      end
      req_ready_i[p]  = !req_stall && chance(ready_lvl);
      rsp_ready_i[p]  = chance(ready_lvl);
      wide_ready_i[p] = chance(ready_lvl);
    end
  endtask

  task automatic run_cycles(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      drive_inputs();
    end
  endtask

  task automatic end_test(input int unsigned num, input string name, input int unsigned base);
    int unsigned errs;
    errs = total_errs() - base;
    if (errs == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", num, name, errs);
    end
  endtask

  initial begin
    int unsigned base;
    int unsigned rsp_before;
    int unsigned wide_before;
    int unsigned waited;
    lfsr_q       = 32'h7ca65110;
    reset_i      = 1'b1;
    xy_id_i      = '{x: 3'd2, y: 3'd2};
    req_valid_i  = '0;
    rsp_valid_i  = '0;
    wide_valid_i = '0;
    req_data_i   = '0;
    rsp_data_i   = '0;
    wide_data_i  = '0;
    req_ready_i  = '1;
    rsp_ready_i  = '1;
    wide_ready_i = '1;
    offer_lvl    = 0;
    ready_lvl    = 8;
    req_stall    = 1'b0;
    fixed_dst_en = 1'b0;
    fixed_dst    = '0;
    tb_errs      = 0;
    tests_failed = 0;
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    base = total_errs();
    run_cycles(2);
    end_test(1, "reset", base);

    // ==================================================================
    // Directed routing, then random and stress traffic
    // ==================================================================
    base         = total_errs();
    offer_lvl    = 8;
    fixed_dst_en = 1'b1;
    for (int unsigned d = 0; d < NumPorts; d++) begin
      fixed_dst = probe_dst(d);
      run_cycles(RouteCycles);
    end
    end_test(2, "routing", base);

    base         = total_errs();
    fixed_dst_en = 1'b0;
    offer_lvl    = 4;
    ready_lvl    = 6;
    run_cycles(400);
    end_test(3, "random traffic", base);

    base      = total_errs();
    offer_lvl = 8;
    ready_lvl = 1;
    run_cycles(300);
    end_test(4, "back-pressure", base);

    base         = total_errs();
    ready_lvl    = 8;
    fixed_dst_en = 1'b1;
    fixed_dst    = probe_dst(4);   // All inputs to the local port
    run_cycles(200);
    end_test(5, "contention", base);

    base         = total_errs();
    fixed_dst_en = 1'b0;
    offer_lvl    = 6;
    ready_lvl    = 6;
    req_stall    = 1'b1;
    rsp_before   = rsp_xfers;
    wide_before  = wide_xfers;
    run_cycles(300);
    if (rsp_xfers == rsp_before || wide_xfers == wide_before) begin
      tb_errs++;
      $display("ERROR: response or wide network stopped while requests were stalled");
    end
    end_test(6, "request stall", base);

    base      = total_errs();
    offer_lvl = 0;
    ready_lvl = 8;
    req_stall = 1'b0;
    waited    = 0;
    while (busy() && waited < DrainCycles) begin
      run_cycles(1);
      waited++;
    end
    if (busy()) begin
      tb_errs++;
      $display("ERROR: %0d flits still queued after drain",
               req_pending + rsp_pending + wide_pending);
    end
    end_test(7, "drain", base);

    $display("tests: 7 run, %0d failed; errors: %0d; transfers req %0d rsp %0d wide %0d",
             tests_failed, total_errs(), req_xfers, rsp_xfers, wide_xfers);
    if (tests_failed == 0 && total_errs() == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: project.f
floo_pkg.sv
floo_fifo.sv
floo_route_select.sv
floo_switch_alloc.sv
floo_router.sv
floo_narrow_wide_router.sv
tb_floo_checker.sv
tb_floo_router.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_floo_router -f project.f -o tb_floo_router

out=$(./obj_dir/tb_floo_router)
echo "$out"

echo "$out" | grep -q '^\*\* PASS \*\*$'
